//--- Bender.yml
package:
  name: rv32i_decode

sources:
  - rv32i_pkg.sv
  - regfile.sv
  - control_rom.sv
  - branch_unit.sv
  - pipe_reg.sv
  - id_stage.sv
  - decode_top.sv
  - target: test
    files:
      - decode_chk.sv
      - tb_decode.sv

//--- branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  rv32i_pkg::rv32i_opcode_t   opcode_i,
    input  rv32i_pkg::branch_funct3_t  cmpop_i,
    input  logic                       cmp_imm_i,
    input  logic [rv32i_pkg::xlen-1:0] rs1_val_i,
    input  logic [rv32i_pkg::xlen-1:0] rs2_val_i,
    input  logic [rv32i_pkg::xlen-1:0] i_imm_i,
    input  logic [rv32i_pkg::xlen-1:0] b_imm_i,
    input  logic [rv32i_pkg::xlen-1:0] j_imm_i,
    input  logic [rv32i_pkg::xlen-1:0] pc_i,
    output logic                       br_en_o,
    output logic [rv32i_pkg::xlen-1:0] target_o,
    output rv32i_pkg::pcmux_sel_t      pcmux_sel_o
);
    import rv32i_pkg::*;

    logic [xlen-1:0] cmp_b;
    logic [xlen-1:0] jalr_sum;

    assign cmp_b    = cmp_imm_i ? i_imm_i : rs2_val_i;
    assign jalr_sum = rs1_val_i + i_imm_i;

    always_comb begin
        case (cmpop_i)
            beq:     br_en_o = (rs1_val_i == cmp_b);
            bne:     br_en_o = (rs1_val_i != cmp_b);
            blt:     br_en_o = ($signed(rs1_val_i) < $signed(cmp_b));
            bge:     br_en_o = ($signed(rs1_val_i) >= $signed(cmp_b));
            bltu:    br_en_o = (rs1_val_i < cmp_b);
            bgeu:    br_en_o = (rs1_val_i >= cmp_b);
            default: br_en_o = 1'b0;
        endcase
    end

    always_comb begin
        target_o    = pc_i + b_imm_i;
        pcmux_sel_o = pc_plus4;
        case (opcode_i)
            op_br: begin
                if (br_en_o) begin
                    pcmux_sel_o = pc_br_target;
                end
            end
            op_jal: begin
                target_o    = pc_i + j_imm_i;
                pcmux_sel_o = pc_br_target;
            end
            op_jalr: begin
                // low bit cleared per the jalr rule
                target_o    = {jalr_sum[xlen-1:1], 1'b0};
                pcmux_sel_o = pc_jalr_target;
            end
            default: ;
        endcase
    end

endmodule

//--- control_rom.sv
`timescale 1ns/1ps

module control_rom (
    input  rv32i_pkg::rv32i_opcode_t opcode_i,
    input  logic [2:0]               funct3_i,
    input  logic [6:0]               funct7_i,
    output rv32i_pkg::ctrl_word_t    ctrl_o
);
    import rv32i_pkg::*;

    always_comb begin
        // defaults, overridden per opcode below
        ctrl_o                = bubble_ctrl;
        ctrl_o.opcode         = opcode_i;
        ctrl_o.aluop          = alu_ops_t'(funct3_i);
        ctrl_o.cmpop          = branch_funct3_t'(funct3_i);
        ctrl_o.alumux2_sel    = alu2_i_imm;
        unique case (opcode_i)
            op_lui: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = rf_u_imm;
            end
            op_auipc: begin
                ctrl_o.aluop        = alu_add;
                ctrl_o.alumux1_sel  = alu1_pc;
                ctrl_o.alumux2_sel  = alu2_u_imm;
                ctrl_o.load_regfile = 1'b1;
            end
            op_jal, op_jalr: begin
                // link value is pc + 4
                ctrl_o.aluop          = alu_add;
                ctrl_o.alumux1_sel    = (opcode_i == op_jal) ? alu1_pc : alu1_rs1;
                ctrl_o.alumux2_sel    = (opcode_i == op_jal) ? alu2_j_imm : alu2_i_imm;
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = rf_pc_plus4;
            end
            op_br: begin
                ctrl_o.aluop       = alu_add;
                ctrl_o.alumux1_sel = alu1_pc;
                ctrl_o.alumux2_sel = alu2_b_imm;
            end
            op_load: begin
                ctrl_o.aluop        = alu_add;
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.mem_byte_en  = 4'b1111;
                case (funct3_i)
                    3'b000:  ctrl_o.regfilemux_sel = rf_lb;
                    3'b001:  ctrl_o.regfilemux_sel = rf_lh;
                    3'b100:  ctrl_o.regfilemux_sel = rf_lbu;
                    3'b101:  ctrl_o.regfilemux_sel = rf_lhu;
                    default: ctrl_o.regfilemux_sel = rf_lw;
                endcase
            end
            op_store: begin
                // byte enables are unshifted, execute aligns them
                ctrl_o.aluop       = alu_add;
                ctrl_o.alumux2_sel = alu2_s_imm;
                ctrl_o.mem_write   = 1'b1;
                case (funct3_i)
                    3'b000:  ctrl_o.mem_byte_en = 4'b0001;
                    3'b001:  ctrl_o.mem_byte_en = 4'b0011;
                    default: ctrl_o.mem_byte_en = 4'b1111;
                endcase
            end
            op_imm, op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                if (opcode_i == op_reg) begin
                    ctrl_o.alumux2_sel = alu2_rs2;
                end
                case (funct3_i)
                    3'b000: begin
                        ctrl_o.aluop = (opcode_i == op_reg && funct7_i[5]) ? alu_sub : alu_add;
                    end
                    3'b101: ctrl_o.aluop = funct7_i[5] ? alu_sra : alu_srl;
                    3'b010, 3'b011: begin
                        // slt and sltu reuse the comparator
                        ctrl_o.cmpop          = funct3_i[0] ? bltu : blt;
                        ctrl_o.cmp_imm        = (opcode_i == op_imm);
                        ctrl_o.regfilemux_sel = rf_br_en;
                    end
                    default: ;
                endcase
            end
            default: ctrl_o = bubble_ctrl;
        endcase
    end

endmodule

//--- decode_chk.sv
`timescale 1ns/1ps

module decode_chk (
    input logic                       clk,
    input logic                       rst,
    input logic                       flush_i,
    input logic                       halt_i,
    input logic [rv32i_pkg::xlen-1:0] if_id_instr_i,
    input logic [rv32i_pkg::xlen-1:0] if_id_pc_i,
    input logic                       ld_rf_i,
    input logic                       mem_read_i,
    input logic                       mem_write_i
);
    import rv32i_pkg::*;

    // reset leaves a bubble in ID/EX and nothing to redirect
    reset_quiet: assert property (@(posedge clk)
        rst |-> !flush_i && !ld_rf_i && !mem_read_i && !mem_write_i)
        else $error("ID/EX or flush not quiet during reset");

    flush_nop: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> (if_id_instr_i == nop_instr) && (if_id_pc_i == '0))
        else $error("IF/ID did not take a nop after a flush");

    halt_flush: assert property (@(posedge clk) disable iff (rst)
        halt_i |-> flush_i)
        else $error("halt raised without a flush");

endmodule

//--- decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rv32i_pkg::xlen-1:0] instr_i,
    input  logic [rv32i_pkg::xlen-1:0] pc_i,
    input  logic                       if_id_ld_i,
    input  logic                       id_ex_ld_i,
    input  logic                       bubble_i,
    input  rv32i_pkg::fwd_sel_t        fwd_a_sel_i,
    input  rv32i_pkg::fwd_sel_t        fwd_b_sel_i,
    input  logic [rv32i_pkg::xlen-1:0] ex_alu_i,
    input  logic [rv32i_pkg::xlen-1:0] mem_alu_i,
    input  logic                       wb_load_i,
    input  logic [4:0]                 wb_rd_i,
    input  logic [rv32i_pkg::xlen-1:0] wb_data_i,
    output rv32i_pkg::ctrl_word_t      ex_ctrl_o,
    output logic [rv32i_pkg::xlen-1:0] ex_pc_o,
    output logic [rv32i_pkg::xlen-1:0] ex_rs1_data_o,
    output logic [rv32i_pkg::xlen-1:0] ex_rs2_data_o,
    output logic [rv32i_pkg::xlen-1:0] ex_i_imm_o,
    output logic [rv32i_pkg::xlen-1:0] ex_s_imm_o,
    output logic [rv32i_pkg::xlen-1:0] ex_b_imm_o,
    output logic [rv32i_pkg::xlen-1:0] ex_u_imm_o,
    output logic [rv32i_pkg::xlen-1:0] ex_j_imm_o,
    output logic [4:0]                 ex_rs1_o,
    output logic [4:0]                 ex_rs2_o,
    output logic [4:0]                 ex_rd_o,
    output logic                       flush_o,
    output logic [rv32i_pkg::xlen-1:0] branch_pc_o,
    output rv32i_pkg::pcmux_sel_t      pcmux_sel_o,
    output logic                       halt_o
);
    import rv32i_pkg::*;

    if_id_t if_id_d, if_id_q;
    id_ex_t id_ex_d, id_ex_q;

    assign if_id_d = '{instr: instr_i, pc: pc_i};

    // a flush replaces the fetched instruction with a nop
    pipe_reg #(.payload_t(if_id_t), .reset_val(if_id_reset)) u_if_id (
        .clk (clk), .rst (rst), .ld_i (if_id_ld_i),
        .flush_i (flush_o), .flush_val_i (if_id_reset),
        .d_i (if_id_d), .q_o (if_id_q)
    );

    id_stage u_id (
        .clk (clk), .rst (rst),
        .instr_i (if_id_q.instr), .pc_i (if_id_q.pc),
        .wb_load_i (wb_load_i), .wb_rd_i (wb_rd_i), .wb_data_i (wb_data_i),
        .ex_alu_i (ex_alu_i), .mem_alu_i (mem_alu_i),
        .fwd_a_sel_i (fwd_a_sel_i), .fwd_b_sel_i (fwd_b_sel_i),
        .bubble_i (bubble_i), .if_id_ld_i (if_id_ld_i), .id_ex_ld_i (id_ex_ld_i),
        .id_ex_o (id_ex_d), .flush_o (flush_o), .branch_pc_o (branch_pc_o),
        .pcmux_sel_o (pcmux_sel_o), .halt_o (halt_o)
    );

    pipe_reg #(.payload_t(id_ex_t), .reset_val(id_ex_reset)) u_id_ex (
        .clk (clk), .rst (rst), .ld_i (id_ex_ld_i), .d_i (id_ex_d), .q_o (id_ex_q)
    );

    assign ex_ctrl_o     = id_ex_q.ctrl;
    assign ex_pc_o       = id_ex_q.pc;
    assign ex_rs1_data_o = id_ex_q.rs1_data;
    assign ex_rs2_data_o = id_ex_q.rs2_data;
    assign ex_i_imm_o    = id_ex_q.i_imm;
    assign ex_s_imm_o    = id_ex_q.s_imm;
    assign ex_b_imm_o    = id_ex_q.b_imm;
    assign ex_u_imm_o    = id_ex_q.u_imm;
    assign ex_j_imm_o    = id_ex_q.j_imm;
    assign ex_rs1_o      = id_ex_q.rs1;
    assign ex_rs2_o      = id_ex_q.rs2;
    assign ex_rd_o       = id_ex_q.rd;

endmodule

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rv32i_pkg::xlen-1:0] instr_i,
    input  logic [rv32i_pkg::xlen-1:0] pc_i,
    input  logic                       wb_load_i,
    input  logic [4:0]                 wb_rd_i,
    input  logic [rv32i_pkg::xlen-1:0] wb_data_i,
    input  logic [rv32i_pkg::xlen-1:0] ex_alu_i,
    input  logic [rv32i_pkg::xlen-1:0] mem_alu_i,
    input  rv32i_pkg::fwd_sel_t        fwd_a_sel_i,
    input  rv32i_pkg::fwd_sel_t        fwd_b_sel_i,
    input  logic                       bubble_i,
    input  logic                       if_id_ld_i,
    input  logic                       id_ex_ld_i,
    output rv32i_pkg::id_ex_t          id_ex_o,
    output logic                       flush_o,
    output logic [rv32i_pkg::xlen-1:0] branch_pc_o,
    output rv32i_pkg::pcmux_sel_t      pcmux_sel_o,
    output logic                       halt_o
);
    import rv32i_pkg::*;

    rv32i_opcode_t   opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1, rs2, rd;
    logic [xlen-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [xlen-1:0] rs1_data, rs2_data;
    logic [xlen-1:0] rs1_val, rs2_val;
    ctrl_word_t      ctrl_rom;
    ctrl_word_t      ctrl_bub;
    logic            br_en;

    function automatic logic [xlen-1:0] fwd_pick(
        input fwd_sel_t        sel,
        input logic [xlen-1:0] reg_val,
        input logic [xlen-1:0] ex_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        case (sel)
            fwd_ex_alu:  return ex_val;
            fwd_mem_alu: return mem_val;
            fwd_wb_data: return wb_val;
            default:     return reg_val;
        endcase
    endfunction

    // instruction fields
    assign opcode = rv32i_opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];

    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'h000};
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    control_rom u_ctrl_rom (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl_rom)
    );

    // hazard bubble, or IF/ID held while ID/EX advances
    assign ctrl_bub = (bubble_i || (!if_id_ld_i && id_ex_ld_i)) ? bubble_ctrl : ctrl_rom;

    regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .load_i     (wb_load_i),
        .rd_i       (wb_rd_i),
        .data_i     (wb_data_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // compare operands may come from later stages
    assign rs1_val = fwd_pick(fwd_a_sel_i, rs1_data, ex_alu_i, mem_alu_i, wb_data_i);
    assign rs2_val = fwd_pick(fwd_b_sel_i, rs2_data, ex_alu_i, mem_alu_i, wb_data_i);

    branch_unit u_branch_unit (
        .opcode_i    (ctrl_bub.opcode),
        .cmpop_i     (ctrl_bub.cmpop),
        .cmp_imm_i   (ctrl_bub.cmp_imm),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .i_imm_i     (i_imm),
        .b_imm_i     (b_imm),
        .j_imm_i     (j_imm),
        .pc_i        (pc_i),
        .br_en_o     (br_en),
        .target_o    (branch_pc_o),
        .pcmux_sel_o (pcmux_sel_o)
    );

    // every taken control transfer flushes the fetched instruction
    assign flush_o = (ctrl_bub.opcode == op_br && br_en) ||
                     ctrl_bub.opcode == op_jal || ctrl_bub.opcode == op_jalr;

    // jump to self is the end-of-program idiom
    assign halt_o = (pcmux_sel_o != pc_plus4) && (branch_pc_o == pc_i) && (pc_i != '0);

    always_comb begin
        id_ex_o.ctrl     = ctrl_bub;
        id_ex_o.pc       = pc_i;
        id_ex_o.rs1_data = rs1_data;
        id_ex_o.rs2_data = rs2_data;
        id_ex_o.i_imm    = i_imm;
        id_ex_o.s_imm    = s_imm;
        id_ex_o.b_imm    = b_imm;
        id_ex_o.u_imm    = u_imm;
        id_ex_o.j_imm    = j_imm;
        id_ex_o.rs1      = rs1;
        id_ex_o.rs2      = rs2;
        id_ex_o.rd       = rd;
    end

endmodule

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t reset_val = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     ld_i,
    input  logic     flush_i = 1'b0,
    input  payload_t flush_val_i = reset_val,
    input  payload_t d_i,
    output payload_t q_o
);

    // flush wins over load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_o <= reset_val;
        end else if (flush_i) begin
            q_o <= flush_val_i;
        end else if (ld_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_i,
    input  logic [4:0]                 rd_i,
    input  logic [rv32i_pkg::xlen-1:0] data_i,
    input  logic [4:0]                 rs1_i,
    input  logic [4:0]                 rs2_i,
    output logic [rv32i_pkg::xlen-1:0] rs1_data_o,
    output logic [rv32i_pkg::xlen-1:0] rs2_data_o
);
    import rv32i_pkg::*;

    logic [xlen-1:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (load_i && rd_i != 5'd0) begin
            regs[rd_i] <= data_i;
        end
    end

    // same-cycle write shows up on the read port
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 :
                        (load_i && rd_i == rs1_i) ? data_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 :
                        (load_i && rd_i == rs2_i) ? data_i : regs[rs2_i];

endmodule

//--- rv32i_pkg.sv
package rv32i_pkg;

    localparam int xlen = 32;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode_t;

    // encodings follow the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_ops_t;

    typedef enum logic [1:0] {pc_plus4, pc_br_target, pc_jalr_target} pcmux_sel_t;

    typedef enum logic [1:0] {fwd_id, fwd_ex_alu, fwd_mem_alu, fwd_wb_data} fwd_sel_t;

    typedef enum logic {alu1_rs1, alu1_pc} alumux1_sel_t;

    typedef enum logic [2:0] {
        alu2_i_imm, alu2_u_imm, alu2_b_imm, alu2_s_imm, alu2_j_imm, alu2_rs2
    } alumux2_sel_t;

    typedef enum logic [3:0] {
        rf_alu_out, rf_br_en, rf_u_imm, rf_lw, rf_pc_plus4, rf_lb, rf_lbu, rf_lh, rf_lhu
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_opcode_t   opcode;
        alu_ops_t        aluop;
        branch_funct3_t  cmpop;
        logic            cmp_imm;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        logic [3:0]      mem_byte_en;
        regfilemux_sel_t regfilemux_sel;
    } ctrl_word_t;

    localparam ctrl_word_t bubble_ctrl = '{
        opcode: op_csr, aluop: alu_add, cmpop: beq, cmp_imm: 1'b0,
        alumux1_sel: alu1_rs1, alumux2_sel: alu2_rs2, load_regfile: 1'b0,
        mem_read: 1'b0, mem_write: 1'b0, mem_byte_en: 4'h0, regfilemux_sel: rf_alu_out
    };

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t      ctrl;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] i_imm;
        logic [xlen-1:0] s_imm;
        logic [xlen-1:0] b_imm;
        logic [xlen-1:0] u_imm;
        logic [xlen-1:0] j_imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
    } id_ex_t;

    localparam if_id_t if_id_reset = '{instr: nop_instr, pc: '0};
    localparam id_ex_t id_ex_reset = '{ctrl: bubble_ctrl, default: '0};

endpackage

//--- tb.f
rv32i_pkg.sv
regfile.sv
control_rom.sv
branch_unit.sv
pipe_reg.sv
id_stage.sv
decode_top.sv
decode_chk.sv
tb_decode.sv

//--- tb_decode.sv
`timescale 1ns/1ps

module tb_decode;
    import rv32i_pkg::*;

    localparam int n_rand  = 60;
    // directed issues and register writes on top of the random ones
    localparam int n_tests = n_rand + 75;
    localparam logic [31:0] filler_instr = 32'h0010_0293;

    typedef struct packed {
        logic [6:0]  opc;
        logic        ld_rf;
        logic        mrd;
        logic        mwr;
        logic [31:0] pc;
        logic [31:0] r1d;
        logic [31:0] r2d;
        logic [31:0] ii;
        logic [31:0] si;
        logic [31:0] bi;
        logic [31:0] ui;
        logic [31:0] ji;
        logic [31:0] tgt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        flush;
        logic        halt;
        logic [1:0]  pcsel;
        logic        hold;
        logic [2:0]  tag;
        logic [31:0] red_cyc;
        logic [31:0] ex_cyc;
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic [31:0] instr_i, pc_i, ex_alu_i, mem_alu_i, wb_data_i;
    logic if_id_ld_i, id_ex_ld_i, bubble_i, wb_load_i;
    logic [4:0] wb_rd_i;
    fwd_sel_t fwd_a_sel_i, fwd_b_sel_i;
    ctrl_word_t ex_ctrl_o;
    logic [31:0] ex_pc_o, ex_rs1_data_o, ex_rs2_data_o;
    logic [31:0] ex_i_imm_o, ex_s_imm_o, ex_b_imm_o, ex_u_imm_o, ex_j_imm_o;
    logic [4:0] ex_rs1_o, ex_rs2_o, ex_rd_o;
    logic flush_o, halt_o;
    logic [31:0] branch_pc_o;
    pcmux_sel_t pcmux_sel_o;

    logic [31:0] regs [32];
    logic [15:0] lfsr = 16'd44;
    logic [31:0] cyc = '0;
    int errors = 0;
    int checks = 0;
    exp_t exp_q[$];
    logic [31:0] snap_ctrl, snap_pc, snap_rd, snap_ii, snap_r1d;

    decode_top DUT (.*);

    bind decode_top decode_chk u_chk (
        .clk (clk), .rst (rst), .flush_i (flush_o), .halt_i (halt_o),
        .if_id_instr_i (if_id_q.instr), .if_id_pc_i (if_id_q.pc),
        .ld_rf_i (id_ex_q.ctrl.load_regfile), .mem_read_i (id_ex_q.ctrl.mem_read),
        .mem_write_i (id_ex_q.ctrl.mem_write)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // taps at x^16 x^14 x^13 x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], b};
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic string test_name(input logic [2:0] tag);
        case (tag)
            3'd0:    return "regfile";
            3'd1:    return "decode";
            3'd2:    return "forward";
            3'd3:    return "branch";
            3'd4:    return "bubble";
            default: return "halt";
        endcase
    endfunction

    function automatic logic [31:0] pick(input logic [1:0] sel, input logic [31:0] r,
                                         input logic [31:0] e, input logic [31:0] m,
                                         input logic [31:0] w);
        return (sel == 2'd1) ? e : (sel == 2'd2) ? m : (sel == 2'd3) ? w : r;
    endfunction

    // expected decode of one word by the RV32I encoding rules
    function automatic exp_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                        input logic [1:0] fa, input logic [1:0] fb,
                                        input logic [31:0] exv, input logic [31:0] memv,
                                        input logic [31:0] wbv, input logic bub);
        exp_t e;
        logic [6:0] op;
        logic [31:0] a, b;
        logic known, taken;
        e = '0;
        op = w[6:0];
        e.pc = pc;
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.rd = w[11:7];
        e.r1d = regs[e.rs1];
        e.r2d = regs[e.rs2];
        e.ii = {{20{w[31]}}, w[31:20]};
        e.si = {{20{w[31]}}, w[31:25], w[11:7]};
        e.bi = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.ui = {w[31:12], 12'h000};
        e.ji = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        known = op inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33};
        if (bub || !known) begin
            e.opc = 7'h73;
            return e;
        end
        e.opc = op;
        e.ld_rf = !(op inside {7'h63, 7'h23});
        e.mrd = (op == 7'h03);
        e.mwr = (op == 7'h23);
        a = pick(fa, e.r1d, exv, memv, wbv);
        b = pick(fb, e.r2d, exv, memv, wbv);
        case (w[14:12])
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = !($signed(a) < $signed(b));
            3'd6:    taken = (a < b);
            3'd7:    taken = !(a < b);
            default: taken = 1'b0;
        endcase
        if (op == 7'h63 && taken) begin
            e.flush = 1'b1;
            e.tgt = pc + e.bi;
            e.pcsel = 2'd1;
        end else if (op == 7'h6f) begin
            e.flush = 1'b1;
            e.tgt = pc + e.ji;
            e.pcsel = 2'd1;
        end else if (op == 7'h67) begin
            e.flush = 1'b1;
            e.tgt = (a + e.ii) & ~32'd1;
            e.pcsel = 2'd2;
        end
        e.halt = e.flush && (e.tgt == pc) && (pc != 0);
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_redirect(input exp_t e);
        string n;
        n = test_name(e.tag);
        check({n, ".flush"}, e.flush, flush_o);
        check({n, ".halt"}, e.halt, halt_o);
        check({n, ".pcmux_sel"}, e.pcsel, pcmux_sel_o);
        if (e.flush) begin
            check({n, ".branch_pc"}, e.tgt, branch_pc_o);
        end
    endtask

    task automatic check_ex(input exp_t e);
        string n;
        n = test_name(e.tag);
        if (e.hold) begin
            check({n, ".hold_ctrl"}, snap_ctrl, 32'(ex_ctrl_o));
            check({n, ".hold_pc"}, snap_pc, ex_pc_o);
            check({n, ".hold_rd"}, snap_rd, ex_rd_o);
            check({n, ".hold_i_imm"}, snap_ii, ex_i_imm_o);
            check({n, ".hold_rs1_data"}, snap_r1d, ex_rs1_data_o);
            return;
        end
        check({n, ".opcode"}, e.opc, 32'(ex_ctrl_o.opcode));
        check({n, ".load_regfile"}, e.ld_rf, ex_ctrl_o.load_regfile);
        check({n, ".mem_read"}, e.mrd, ex_ctrl_o.mem_read);
        check({n, ".mem_write"}, e.mwr, ex_ctrl_o.mem_write);
        check({n, ".pc"}, e.pc, ex_pc_o);
        check({n, ".rs1_data"}, e.r1d, ex_rs1_data_o);
        check({n, ".rs2_data"}, e.r2d, ex_rs2_data_o);
        check({n, ".i_imm"}, e.ii, ex_i_imm_o);
        check({n, ".s_imm"}, e.si, ex_s_imm_o);
        check({n, ".b_imm"}, e.bi, ex_b_imm_o);
        check({n, ".u_imm"}, e.ui, ex_u_imm_o);
        check({n, ".j_imm"}, e.ji, ex_j_imm_o);
        check({n, ".rs1"}, e.rs1, ex_rs1_o);
        check({n, ".rs2"}, e.rs2, ex_rs2_o);
        check({n, ".rd"}, e.rd, ex_rd_o);
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            foreach (exp_q[k]) begin
                if (exp_q[k].red_cyc == cyc && !exp_q[k].hold) check_redirect(exp_q[k]);
                if (exp_q[k].ex_cyc == cyc) check_ex(exp_q[k]);
            end
            while (exp_q.size() > 0 && exp_q[0].ex_cyc <= cyc) begin
                void'(exp_q.pop_front());
            end
        end
        snap_ctrl = 32'(ex_ctrl_o);
        snap_pc = ex_pc_o;
        snap_rd = ex_rd_o;
        snap_ii = ex_i_imm_o;
        snap_r1d = ex_rs1_data_o;
    end

    task automatic write_reg(input logic [4:0] r, input logic [31:0] v);
        @(posedge clk);
        wb_load_i <= 1'b1;
        wb_rd_i <= r;
        wb_data_i <= v;
        if (r != 0) regs[r] = v;
        @(posedge clk);
        wb_load_i <= 1'b0;
    endtask

    // mode 0 plain, 1 bubble_i, 2 IF/ID stall, 3 ID/EX hold, 4 same-cycle write of x7
    task automatic issue(input logic [31:0] ins, input logic [31:0] pc, input logic [1:0] fa,
                         input logic [1:0] fb, input logic [31:0] exv, input logic [31:0] memv,
                         input logic [31:0] wbv, input int mode, input logic [2:0] tag);
        exp_t e, f;
        logic [31:0] a;
        @(posedge clk);
        a = cyc + 1;
        instr_i <= ins;
        pc_i <= pc;
        fwd_a_sel_i <= fwd_sel_t'(fa);
        fwd_b_sel_i <= fwd_sel_t'(fb);
        ex_alu_i <= exv;
        mem_alu_i <= memv;
        wb_data_i <= wbv;
        if (mode == 4) regs[7] = wbv;
        e = ref_decode(ins, pc, fa, fb, exv, memv, wbv, mode == 1 || mode == 2);
        e.tag = tag;
        e.red_cyc = a + 1;
        e.ex_cyc = a + 2;
        e.hold = (mode == 3);
        exp_q.push_back(e);
        if (mode == 2) begin
            e = ref_decode(ins, pc, fa, fb, exv, memv, wbv, 1'b0);
            e.tag = tag;
            e.red_cyc = a + 2;
            e.ex_cyc = a + 3;
            exp_q.push_back(e);
        end
        @(posedge clk);
        instr_i <= filler_instr;
        pc_i <= pc + 4;
        bubble_i <= (mode == 1);
        if_id_ld_i <= (mode != 2);
        id_ex_ld_i <= (mode != 3);
        if (mode == 4) begin
            wb_load_i <= 1'b1;
            wb_rd_i <= 5'd7;
        end
        if (mode != 2) begin
            // a flushing instruction turns the next fetch into a nop
            if (e.flush) f = ref_decode(nop_instr, '0, 2'd0, 2'd0, '0, '0, '0, 1'b0);
            else f = ref_decode(filler_instr, pc + 4, 2'd0, 2'd0, '0, '0, '0, 1'b0);
            f.tag = tag;
            f.red_cyc = a + 2;
            f.ex_cyc = a + 3;
            exp_q.push_back(f);
        end
        @(posedge clk);
        instr_i <= nop_instr;
        bubble_i <= 1'b0;
        if_id_ld_i <= 1'b1;
        id_ex_ld_i <= 1'b1;
        wb_load_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] w, v;
        logic [6:0] ops [11];
        ops = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33, 7'h73, 7'h0f};
        foreach (regs[k]) regs[k] = '0;
        rst = 1'b1;
        instr_i = nop_instr;
        pc_i = '0;
        if_id_ld_i = 1'b1;
        id_ex_ld_i = 1'b1;
        bubble_i = 1'b0;
        fwd_a_sel_i = fwd_id;
        fwd_b_sel_i = fwd_id;
        ex_alu_i = '0;
        mem_alu_i = '0;
        wb_data_i = '0;
        wb_load_i = 1'b0;
        wb_rd_i = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // register file writes, x0 included
        for (int r = 0; r < 32; r++) write_reg(r[4:0], rand_bits(32));
        write_reg(5'd3, 32'hffff_fff0);
        write_reg(5'd4, 32'h0000_0010);
        for (int r = 0; r < 32; r += 2) begin
            issue(enc_r(5'd9, r[4:0], 5'(r + 1)), 32'h40 + r, 0, 0, 0, 0, 0, 0, 3'd0);
        end
        issue(enc_r(5'd9, 5'd7, 5'd8), 32'h80, 0, 0, 0, 0, 32'h1234_5678, 4, 3'd0);
        issue(enc_r(5'd9, 5'd7, 5'd7), 32'h84, 0, 0, 0, 0, 0, 0, 3'd0);

        for (int k = 0; k < n_rand; k++) begin
            w = rand_bits(32);
            w[6:0] = ops[rand_bits(4) % 11];
            issue(w, rand_bits(30) << 2, rand_bits(2), rand_bits(2),
                  rand_bits(32), rand_bits(32), rand_bits(32), 0, 3'd1);
        end

        // the selected source matches x2 while the others do not
        for (int s = 0; s < 4; s++) begin
            v = regs[2];
            issue(enc_b(13'd32, 5'd2, (s == 0) ? 5'd2 : 5'd1, 3'd0), 32'h100, s, 0,
                  (s == 1) ? v : ~v, (s == 2) ? v : ~v, (s == 3) ? v : ~v, 0, 3'd2);
            issue(enc_b(13'd32, (s == 0) ? 5'd2 : 5'd1, 5'd2, 3'd0), 32'h120, 0, s,
                  (s == 1) ? v : ~v, (s == 2) ? v : ~v, (s == 3) ? v : ~v, 0, 3'd2);
        end

        foreach (ops[k]) begin
            if (k < 6) begin
                w = enc_b(13'd16, 5'd4, 5'd3, (k < 2) ? 3'(k) : 3'(k + 2));
                issue(w, 32'h200 + 16 * k, 0, 0, 0, 0, 0, 0, 3'd3);
            end
        end
        issue(enc_b(13'h1ff8, 5'd3, 5'd3, 3'd0), 32'h280, 0, 0, 0, 0, 0, 0, 3'd3);
        issue({20'h04000, 5'd1, 7'h6f}, 32'h300, 0, 0, 0, 0, 0, 0, 3'd3);
        issue({12'd5, 5'd4, 3'd0, 5'd1, 7'h67}, 32'h320, 0, 0, 0, 0, 0, 0, 3'd3);

        // bubble, IF/ID stall and ID/EX hold
        issue({20'h04000, 5'd1, 7'h6f}, 32'h400, 0, 0, 0, 0, 0, 1, 3'd4);
        issue(32'h0050_0313, 32'h410, 0, 0, 0, 0, 0, 2, 3'd4);
        issue(32'h0050_0313, 32'h420, 0, 0, 0, 0, 0, 3, 3'd4);

        // branch to self
        issue(enc_b(13'd0, 5'd0, 5'd0, 3'd0), 32'h500, 0, 0, 0, 0, 0, 0, 3'd5);
        issue(enc_b(13'd0, 5'd0, 5'd0, 3'd0), 32'h0, 0, 0, 0, 0, 0, 0, 3'd5);
        issue(enc_b(13'd0, 5'd0, 5'd0, 3'd1), 32'h500, 0, 0, 0, 0, 0, 0, 3'd5);

        wait (exp_q.size() == 0);
        repeat (2) @(posedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (n_tests * 4 + 200) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", n_tests * 4 + 200);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
